/* all.f */
video_pkg.sv
menu_pkg.sv
video_timing.sv
pointer_tracker.sv
pointer_latch.sv
pixel_painter.sv
menu_screen.sv
tb_menu_screen.sv

/* menu_pkg.sv */
package menu_pkg;

    //////////////////////////////
    // mouse and pointer types
    //////////////////////////////

    // dx and dy are 9-bit two's complement
    // buttons: bit 0 left, bit 1 right
    typedef struct packed {
        logic [8:0] dx;
        logic [8:0] dy;
        logic [2:0] buttons;
    } mouse_packet_t;

    // colour bit 0 red, bit 1 green, bit 2 blue
    typedef struct packed {
        video_pkg::coord_t x;
        video_pkg::coord_t y;
        logic [2:0]        colour;
    } pointer_t;

    // level 1 to 3
    typedef logic [1:0] difficulty_t;

    localparam video_pkg::coord_t pointer_size         = 10'd16;
    localparam logic [2:0]        pointer_reset_colour = 3'd2;
    localparam difficulty_t       difficulty_reset     = 2'd1;

    //////////////////////////////
    // menu geometry
    //////////////////////////////

    // all bounds inclusive
    localparam video_pkg::coord_t start_x_lo = 10'd240;
    localparam video_pkg::coord_t start_x_hi = 10'd330;
    localparam video_pkg::coord_t start_y_lo = 10'd285;
    localparam video_pkg::coord_t start_y_hi = 10'd307;

    // the three difficulty boxes share one row
    localparam video_pkg::coord_t diff_y_lo  = 10'd360;
    localparam video_pkg::coord_t diff_y_hi  = 10'd400;
    localparam video_pkg::coord_t diff1_x_lo = 10'd300;
    localparam video_pkg::coord_t diff1_x_hi = 10'd340;
    localparam video_pkg::coord_t diff2_x_lo = 10'd380;
    localparam video_pkg::coord_t diff2_x_hi = 10'd420;
    localparam video_pkg::coord_t diff3_x_lo = 10'd460;
    localparam video_pkg::coord_t diff3_x_hi = 10'd500;

    // point inside a box, edges included
    function automatic logic in_box(
        input video_pkg::coord_t x,
        input video_pkg::coord_t y,
        input video_pkg::coord_t x_lo,
        input video_pkg::coord_t x_hi,
        input video_pkg::coord_t y_lo,
        input video_pkg::coord_t y_hi
    );
        return (x >= x_lo) && (x <= x_hi) && (y >= y_lo) && (y <= y_hi);
    endfunction

endpackage

/* menu_screen.sv */
`timescale 1ns/100ps

module menu_screen (
    input  logic                     in_clk,
    input  logic                     reset,
    input  logic                     packet_valid,
    input  menu_pkg::mouse_packet_t  packet,
    output video_pkg::vga_out_t      vga,
    output logic                     start,
    output menu_pkg::difficulty_t    difficulty
);

    video_pkg::scan_t       scan;
    menu_pkg::pointer_t     pointer;
    menu_pkg::pointer_t     shown_pointer;
    menu_pkg::difficulty_t  shown_difficulty;

    // raster position and syncs
    video_timing u_video_timing (
        .in_clk (in_clk),
        .reset  (reset),
        .scan   (scan)
    );

    // live pointer and menu choices
    pointer_tracker u_pointer_tracker (
        .in_clk       (in_clk),
        .reset        (reset),
        .packet_valid (packet_valid),
        .packet       (packet),
        .pointer      (pointer),
        .start        (start),
        .difficulty   (difficulty)
    );

    // per-frame copy for display
    pointer_latch u_pointer_latch (
        .in_clk           (in_clk),
        .reset            (reset),
        .scan             (scan),
        .pointer          (pointer),
        .difficulty       (difficulty),
        .shown_pointer    (shown_pointer),
        .shown_difficulty (shown_difficulty)
    );

    pixel_painter u_pixel_painter (
        .in_clk           (in_clk),
        .reset            (reset),
        .scan             (scan),
        .shown_pointer    (shown_pointer),
        .shown_difficulty (shown_difficulty),
        .vga              (vga)
    );

endmodule

/* pixel_painter.sv */
`timescale 1ns/100ps

module pixel_painter (
    input  logic                   in_clk,
    input  logic                   reset,
    input  video_pkg::scan_t       scan,
    input  menu_pkg::pointer_t     shown_pointer,
    input  menu_pkg::difficulty_t  shown_difficulty,
    output video_pkg::vga_out_t    vga
);

    logic [10:0]       ptr_x_end;
    logic [10:0]       ptr_y_end;
    logic              on_pointer;
    logic              on_start;
    logic              on_diff1;
    logic              on_diff2;
    logic              on_diff3;
    logic              on_selected;
    video_pkg::rgb_t   colour;

    //////////////////////////////
    // region tests
    //////////////////////////////

    // last covered column and row, one bit wider than the screen
    assign ptr_x_end = {1'b0, shown_pointer.x} + {1'b0, menu_pkg::pointer_size} - 11'd1;
    assign ptr_y_end = {1'b0, shown_pointer.y} + {1'b0, menu_pkg::pointer_size} - 11'd1;

    assign on_pointer = (scan.x >= shown_pointer.x) && ({1'b0, scan.x} <= ptr_x_end)
                     && (scan.y >= shown_pointer.y) && ({1'b0, scan.y} <= ptr_y_end);

    assign on_start = menu_pkg::in_box(scan.x, scan.y,
                                       menu_pkg::start_x_lo, menu_pkg::start_x_hi,
                                       menu_pkg::start_y_lo, menu_pkg::start_y_hi);
    assign on_diff1 = menu_pkg::in_box(scan.x, scan.y,
                                       menu_pkg::diff1_x_lo, menu_pkg::diff1_x_hi,
                                       menu_pkg::diff_y_lo, menu_pkg::diff_y_hi);
    assign on_diff2 = menu_pkg::in_box(scan.x, scan.y,
                                       menu_pkg::diff2_x_lo, menu_pkg::diff2_x_hi,
                                       menu_pkg::diff_y_lo, menu_pkg::diff_y_hi);
    assign on_diff3 = menu_pkg::in_box(scan.x, scan.y,
                                       menu_pkg::diff3_x_lo, menu_pkg::diff3_x_hi,
                                       menu_pkg::diff_y_lo, menu_pkg::diff_y_hi);

    assign on_selected = (on_diff1 && (shown_difficulty == 2'd1))
                      || (on_diff2 && (shown_difficulty == 2'd2))
                      || (on_diff3 && (shown_difficulty == 2'd3));

    //////////////////////////////
    // colour select
    //////////////////////////////

    // pointer on top, then start box, then difficulty boxes
    always_comb begin
        if (!scan.active) begin
            colour = '{r: 4'd0, g: 4'd0, b: 4'd0};
        end else if (on_pointer) begin
            colour.r = {4{shown_pointer.colour[0]}};
            colour.g = {4{shown_pointer.colour[1]}};
            colour.b = {4{shown_pointer.colour[2]}};
        end else if (on_start) begin
            colour = '{r: 4'd15, g: 4'd15, b: 4'd15};
        end else if (on_selected) begin
            colour = '{r: 4'd0, g: 4'd15, b: 4'd0};
        end else if (on_diff1 || on_diff2 || on_diff3) begin
            colour = '{r: 4'd8, g: 4'd8, b: 4'd8};
        end else begin
            colour = '{r: 4'd0, g: 4'd0, b: 4'd0};
        end
    end

    // one cycle from scan to pins, syncs delayed to match
    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            vga.rgb <= '0;
            vga.hs  <= 1'b1;
            vga.vs  <= 1'b1;
        end else begin
            vga.rgb <= colour;
            vga.hs  <= scan.hs;
            vga.vs  <= scan.vs;
        end
    end

endmodule

/* pointer_latch.sv */
`timescale 1ns/100ps

module pointer_latch (
    input  logic                   in_clk,
    input  logic                   reset,
    input  video_pkg::scan_t       scan,
    input  menu_pkg::pointer_t     pointer,
    input  menu_pkg::difficulty_t  difficulty,
    output menu_pkg::pointer_t     shown_pointer,
    output menu_pkg::difficulty_t  shown_difficulty
);

    logic sample;

    // first clock of the first blanking line
    assign sample = (scan.x == '0) && (scan.y == video_pkg::v_active);

    // snapshot once per frame so the picture never tears
    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            shown_pointer.x      <= '0;
            shown_pointer.y      <= '0;
            shown_pointer.colour <= menu_pkg::pointer_reset_colour;
            shown_difficulty     <= menu_pkg::difficulty_reset;
        end else if (sample) begin
            shown_pointer    <= pointer;
            shown_difficulty <= difficulty;
        end
    end

endmodule

/* pointer_tracker.sv */
`timescale 1ns/100ps

module pointer_tracker (
    input  logic                     in_clk,
    input  logic                     reset,
    input  logic                     packet_valid,
    input  menu_pkg::mouse_packet_t  packet,
    output menu_pkg::pointer_t       pointer,
    output logic                     start,
    output menu_pkg::difficulty_t    difficulty
);

    logic signed [11:0]    x_sum;
    logic signed [11:0]    y_sum;
    video_pkg::coord_t     x_next;
    video_pkg::coord_t     y_next;
    logic [2:0]            colour_next;
    logic                  left;
    logic                  right;
    logic                  hit_start;
    logic                  hit_diff1;
    logic                  hit_diff2;
    logic                  hit_diff3;

    assign left  = packet.buttons[0];
    assign right = packet.buttons[1];

    //////////////////////////////
    // movement with clamping
    //////////////////////////////

    // screen y grows downward, mouse dy grows upward
    always_comb begin
        x_sum = $signed({2'b00, pointer.x}) + $signed({{3{packet.dx[8]}}, packet.dx});
        y_sum = $signed({2'b00, pointer.y}) - $signed({{3{packet.dy[8]}}, packet.dy});

        if (x_sum[11]) begin
            x_next = '0;
        end else if (x_sum[10:0] >= {1'b0, video_pkg::h_active}) begin
            x_next = video_pkg::h_active - 10'd1;
        end else begin
            x_next = x_sum[9:0];
        end

        if (y_sum[11]) begin
            y_next = '0;
        end else if (y_sum[10:0] >= {1'b0, video_pkg::v_active}) begin
            y_next = video_pkg::v_active - 10'd1;
        end else begin
            y_next = y_sum[9:0];
        end
    end

    // right wins over left, wraps mod 8
    always_comb begin
        if (right) begin
            colour_next = pointer.colour + 3'd1;
        end else if (left) begin
            colour_next = pointer.colour - 3'd1;
        end else begin
            colour_next = pointer.colour;
        end
    end

    //////////////////////////////
    // hit tests
    //////////////////////////////

    // position from before this packet
    assign hit_start = menu_pkg::in_box(pointer.x, pointer.y,
                                        menu_pkg::start_x_lo, menu_pkg::start_x_hi,
                                        menu_pkg::start_y_lo, menu_pkg::start_y_hi);
    assign hit_diff1 = menu_pkg::in_box(pointer.x, pointer.y,
                                        menu_pkg::diff1_x_lo, menu_pkg::diff1_x_hi,
                                        menu_pkg::diff_y_lo, menu_pkg::diff_y_hi);
    assign hit_diff2 = menu_pkg::in_box(pointer.x, pointer.y,
                                        menu_pkg::diff2_x_lo, menu_pkg::diff2_x_hi,
                                        menu_pkg::diff_y_lo, menu_pkg::diff_y_hi);
    assign hit_diff3 = menu_pkg::in_box(pointer.x, pointer.y,
                                        menu_pkg::diff3_x_lo, menu_pkg::diff3_x_hi,
                                        menu_pkg::diff_y_lo, menu_pkg::diff_y_hi);

    //////////////////////////////
    // state
    //////////////////////////////

    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            pointer.x      <= '0;
            pointer.y      <= '0;
            pointer.colour <= menu_pkg::pointer_reset_colour;
            start          <= 1'b0;
            difficulty     <= menu_pkg::difficulty_reset;
        end else if (packet_valid) begin
            pointer.x      <= x_next;
            pointer.y      <= y_next;
            pointer.colour <= colour_next;
            // start holds while left is down outside the box
            if (!left) begin
                start <= 1'b0;
            end else if (hit_start) begin
                start <= 1'b1;
            end
            if (left && hit_diff1) begin
                difficulty <= 2'd1;
            end else if (left && hit_diff2) begin
                difficulty <= 2'd2;
            end else if (left && hit_diff3) begin
                difficulty <= 2'd3;
            end
        end
    end

endmodule

/* tb_menu_screen.sv */
`timescale 1ns/100ps

module tb_menu_screen;

    // 640x480 timing in pixel clocks
    localparam int hs_period    = 800;
    localparam int hs_low       = 96;
    localparam int frame_cycles = 420000;
    localparam int vs_low       = 1600;
    // the tests run a little under ten frames
    localparam int timeout_cycles = 12 * frame_cycles;

    localparam logic [11:0] black = 12'h000;
    localparam logic [11:0] white = 12'hfff;
    localparam logic [11:0] green = 12'h0f0;
    localparam logic [11:0] grey  = 12'h888;

    logic                    in_clk;
    logic                    reset;
    logic                    packet_valid;
    menu_pkg::mouse_packet_t packet;
    video_pkg::vga_out_t     vga;
    logic                    start;
    menu_pkg::difficulty_t   difficulty;

    int         seed;
    int         cycle_count;
    string      cur_test;
    int         cur_row;
    int         cur_col;
    // expected pointer and menu state
    int         exp_x;
    int         exp_y;
    logic [2:0] exp_colour;
    logic       exp_start;
    logic [1:0] exp_diff;

    menu_screen dut (.*);

    initial begin
        in_clk = 1'b0;
        forever #2 in_clk = ~in_clk;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge in_clk);
            cycle_count++;
            if (cycle_count >= timeout_cycles) begin
                $display("timeout: no end of test after %0d cycles", cycle_count);
                report_failure();
            end
        end
    end

    //////////////////////////////
    // checking
    //////////////////////////////

    task automatic report_failure();
        $display("Done: errors found");
        $fatal(1, "stopped at first failing check");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("ERR %s %s expected %0d actual %0d", cur_test, what, expected, actual);
            report_failure();
        end
    endtask

    // bit 0 red, bit 1 green, bit 2 blue
    function automatic logic [11:0] colour_rgb(input logic [2:0] c);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = c[0] ? 4'd15 : 4'd0;
        g = c[1] ? 4'd15 : 4'd0;
        b = c[2] ? 4'd15 : 4'd0;
        return {r, g, b};
    endfunction

    function automatic bit within_box(input int x, input int y, input int x_lo, input int x_hi,
                                      input int y_lo, input int y_hi);
        return (x >= x_lo) && (x <= x_hi) && (y >= y_lo) && (y <= y_hi);
    endfunction

    function automatic int clamp_coord(input int value, input int size);
        if (value < 0) begin
            return 0;
        end
        if (value > size - 1) begin
            return size - 1;
        end
        return value;
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic send_packet(input logic [8:0] dx, input logic [8:0] dy,
                               input logic [2:0] buttons);
        logic left;
        int   dx_int;
        int   dy_int;
        left   = buttons[0];
        dx_int = $signed(dx);
        dy_int = $signed(dy);
        // hit tests see the position before the move
        if (!left) begin
            exp_start = 1'b0;
        end else if (within_box(exp_x, exp_y, 240, 330, 285, 307)) begin
            exp_start = 1'b1;
        end
        if (left && within_box(exp_x, exp_y, 300, 340, 360, 400)) begin
            exp_diff = 2'd1;
        end else if (left && within_box(exp_x, exp_y, 380, 420, 360, 400)) begin
            exp_diff = 2'd2;
        end else if (left && within_box(exp_x, exp_y, 460, 500, 360, 400)) begin
            exp_diff = 2'd3;
        end
        if (buttons[1]) begin
            exp_colour = exp_colour + 3'd1;
        end else if (left) begin
            exp_colour = exp_colour - 3'd1;
        end
        exp_x = clamp_coord(exp_x + dx_int, 640);
        exp_y = clamp_coord(exp_y - dy_int, 480);
        @(posedge in_clk);
        packet_valid <= 1'b1;
        packet       <= {dx, dy, buttons};
        @(posedge in_clk);
        packet_valid <= 1'b0;
        @(negedge in_clk);
        check_value("start", exp_start, start);
        check_value("difficulty", exp_diff, difficulty);
    endtask

    // steps of at most 200 so no packet clamps
    task automatic move_to(input int tx, input int ty);
        int step_x;
        int step_y;
        while ((exp_x != tx) || (exp_y != ty)) begin
            step_x = (tx - exp_x > 200) ? 200 : ((tx - exp_x < -200) ? -200 : tx - exp_x);
            step_y = (exp_y - ty > 200) ? 200 : ((exp_y - ty < -200) ? -200 : exp_y - ty);
            send_packet(step_x[8:0], step_y[8:0], 3'b000);
        end
    endtask

    //////////////////////////////
    // raster following
    //////////////////////////////

    // returns at the first negedge where the sync has just reached level
    task automatic wait_sync(input bit vertical, input logic level);
        @(negedge in_clk);
        while ((vertical ? vga.vs : vga.hs) === level) begin
            @(negedge in_clk);
        end
        while ((vertical ? vga.vs : vga.hs) !== level) begin
            @(negedge in_clk);
        end
    endtask

    // vs rises on line 492, row 0 follows the hs rise of line 524
    task automatic wait_frame_start();
        wait_sync(1'b1, 1'b1);
        repeat (33) wait_sync(1'b0, 1'b1);
        cur_row = 0;
        cur_col = -1;
    endtask

    // pixels of one frame go in scan order
    task automatic sample_pixel(input int col, input int row, output logic [11:0] seen);
        if (row > cur_row) begin
            repeat (row - cur_row) wait_sync(1'b0, 1'b1);
            repeat (48 + col) @(negedge in_clk);
        end else if ((row == cur_row) && (cur_col < 0)) begin
            repeat (48 + col) @(negedge in_clk);
        end else if ((row == cur_row) && (col > cur_col)) begin
            repeat (col - cur_col) @(negedge in_clk);
        end else begin
            $display("pixel (%0d,%0d) asked for after the scan had passed it", col, row);
            report_failure();
        end
        cur_row = row;
        cur_col = col;
        seen    = vga.rgb;
    endtask

    task automatic check_pixel(input int col, input int row, input logic [11:0] expected);
        logic [11:0] seen;
        sample_pixel(col, row, seen);
        assert (seen == expected) else begin
            $display("ERR %s pixel (%0d,%0d) expected %03h actual %03h",
                     cur_test, col, row, expected, seen);
            report_failure();
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_reset_timing();
        int t0;
        int t1;
        int t2;
        cur_test = "reset_timing";
        repeat (8) @(posedge in_clk);
        @(negedge in_clk);
        check_value("rgb in reset", 0, vga.rgb);
        check_value("hs in reset", 1, vga.hs);
        check_value("vs in reset", 1, vga.vs);
        repeat (8) @(posedge in_clk);
        reset <= 1'b1;
        exp_x      = 0;
        exp_y      = 0;
        exp_colour = 3'd2;
        exp_start  = 1'b0;
        exp_diff   = 2'd1;
        wait_sync(1'b0, 1'b0);
        t0 = cycle_count;
        wait_sync(1'b0, 1'b1);
        t1 = cycle_count;
        wait_sync(1'b0, 1'b0);
        t2 = cycle_count;
        check_value("hs low", hs_low, t1 - t0);
        check_value("hs period", hs_period, t2 - t0);
        wait_sync(1'b1, 1'b0);
        t0 = cycle_count;
        wait_sync(1'b1, 1'b1);
        t1 = cycle_count;
        wait_sync(1'b1, 1'b0);
        t2 = cycle_count;
        check_value("vs low", vs_low, t1 - t0);
        check_value("vs period", frame_cycles, t2 - t0);
    endtask

    task automatic test_reset_screen();
        cur_test = "reset_screen";
        check_value("start", 0, start);
        check_value("difficulty", 1, difficulty);
        wait_frame_start();
        check_pixel(5, 5, green);
        check_pixel(600, 100, black);
        check_pixel(250, 290, white);
        check_pixel(310, 380, green);
        check_pixel(390, 380, grey);
    endtask

    task automatic test_movement();
        logic [31:0] r;
        logic [11:0] seen;
        cur_test = "movement";
        // packets before line 480 reach the next frame
        wait_sync(1'b1, 1'b1);
        repeat (6) begin
            r = $random(seed);
            send_packet(r[8:0], r[17:9], 3'b000);
        end
        repeat (3) send_packet(9'h100, 9'd0, 3'b000);
        send_packet(9'd0, 9'h100, 3'b000);
        wait_frame_start();
        // x is clamped to 0, so look above the corner
        sample_pixel(exp_x, exp_y - 1, seen);
        assert (seen != colour_rgb(exp_colour)) else begin
            $display("ERR %s pixel above pointer expected not %03h actual %03h",
                     cur_test, colour_rgb(exp_colour), seen);
            report_failure();
        end
        check_pixel(exp_x, exp_y, colour_rgb(exp_colour));
    endtask

    task automatic test_start_select();
        cur_test = "start_select";
        wait_sync(1'b1, 1'b1);
        move_to(250, 290);
        send_packet(9'd0, 9'd0, 3'b001);
        check_value("start after click", 1, start);
        send_packet(9'd0, 9'd0, 3'b000);
        check_value("start after release", 0, start);
        move_to(100, 100);
        wait_frame_start();
        // left click stepped colour 2 down to 1
        check_pixel(100, 100, colour_rgb(3'd1));
        // still well before line 480, so the next frame shows it
        send_packet(9'd0, 9'd0, 3'b010);
        wait_frame_start();
        // right click brings colour 1 up to 2
        check_pixel(100, 100, colour_rgb(3'd2));
        check_pixel(116, 100, black);
    endtask

    task automatic test_difficulty();
        cur_test = "difficulty";
        wait_sync(1'b1, 1'b1);
        move_to(465, 365);
        send_packet(9'd0, 9'd0, 3'b001);
        check_value("difficulty after box 3", 3, difficulty);
        move_to(100, 100);
        send_packet(9'd0, 9'd0, 3'b001);
        check_value("difficulty after miss", 3, difficulty);
        wait_frame_start();
        check_pixel(310, 395, grey);
        check_pixel(470, 395, green);
    endtask

    initial begin
        reset        = 1'b0;
        packet_valid = 1'b0;
        packet       = '0;
        seed         = 32'ha75f3ff4;
        test_reset_timing();
        test_reset_screen();
        test_movement();
        test_start_select();
        test_difficulty();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* video_pkg.sv */
package video_pkg;

    //////////////////////////////
    // screen coordinates
    //////////////////////////////

    // wide enough for both counters, up to 799 and 524
    typedef logic [9:0] coord_t;

    //////////////////////////////
    // 640x480 timing
    //////////////////////////////

    // horizontal, in pixel clocks
    localparam coord_t h_active = 10'd640;
    localparam coord_t h_front  = 10'd16;
    localparam coord_t h_sync   = 10'd96;
    localparam coord_t h_back   = 10'd48;
    localparam coord_t h_total  = h_active + h_front + h_sync + h_back;

    // vertical, in lines
    localparam coord_t v_active = 10'd480;
    localparam coord_t v_front  = 10'd10;
    localparam coord_t v_sync   = 10'd2;
    localparam coord_t v_back   = 10'd33;
    localparam coord_t v_total  = v_active + v_front + v_sync + v_back;

    // decode points for the counters
    localparam coord_t h_sync_start = h_active + h_front;
    localparam coord_t h_sync_end   = h_sync_start + h_sync;
    localparam coord_t h_last       = h_total - 10'd1;
    localparam coord_t v_sync_start = v_active + v_front;
    localparam coord_t v_sync_end   = v_sync_start + v_sync;
    localparam coord_t v_last       = v_total - 10'd1;

    //////////////////////////////
    // scan and output structs
    //////////////////////////////

    // hs and vs are active low
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
        logic   hs;
        logic   vs;
    } scan_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        rgb_t rgb;
        logic hs;
        logic vs;
    } vga_out_t;

endpackage

/* video_timing.sv */
`timescale 1ns/100ps

module video_timing (
    input  logic              in_clk,
    input  logic              reset,
    output video_pkg::scan_t  scan
);

    video_pkg::coord_t h_cnt;
    video_pkg::coord_t v_cnt;
    logic              line_end;
    logic              frame_end;
    logic              h_active_area;
    logic              v_active_area;
    logic              hs_pulse;
    logic              vs_pulse;

    //////////////////////////////
    // counters
    //////////////////////////////

    assign line_end  = (h_cnt == video_pkg::h_last);
    assign frame_end = (v_cnt == video_pkg::v_last);

    // column counter, runs every clock
    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            h_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // line counter, steps once at the end of each line
    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            v_cnt <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end
    end

    //////////////////////////////
    // decode
    //////////////////////////////

    assign h_active_area = (h_cnt < video_pkg::h_active);
    assign v_active_area = (v_cnt < video_pkg::v_active);

    // sync pulses sit between front and back porch
    assign hs_pulse = (h_cnt >= video_pkg::h_sync_start) && (h_cnt < video_pkg::h_sync_end);
    // v_cnt only moves at line start, so vs does too
    assign vs_pulse = (v_cnt >= video_pkg::v_sync_start) && (v_cnt < video_pkg::v_sync_end);

    always_comb begin
        scan.x      = h_cnt;
        scan.y      = v_cnt;
        scan.active = h_active_area && v_active_area;
        scan.hs     = ~hs_pulse;
        scan.vs     = ~vs_pulse;
    end

endmodule
